/* src/mem_test_pkg.sv */
`default_nettype none

package mem_test_pkg;

  localparam int SRAM_ADDR_W = 18;
  localparam int NUM_S_MAX = 8;

  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

  // One word broadcast to every chip
  typedef struct packed {
    logic                      write;
    sram_addr_t                addr;
    logic [NUM_S_MAX-1:0][7:0] data;
  } stripe_req_t;

  typedef struct packed {
    logic [7:0] data;
  } stripe_rsp_t;

  // APB register map
  localparam logic [7:0] REG_CTRL = 8'h00;
  localparam logic [7:0] REG_SEED = 8'h04;
  localparam logic [7:0] REG_LEN = 8'h08;
  localparam logic [7:0] REG_STATUS = 8'h0C;
  localparam logic [7:0] REG_ERR_COUNT = 8'h10;
  localparam logic [7:0] REG_ERR_ADDR = 8'h14;

  localparam int CTRL_START_BIT = 0;

  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;
  localparam int STATUS_PASS_BIT = 2;

  // Low address byte plus stripe offset, xor seed
  function automatic logic [7:0] pattern_byte(
    input logic [7:0] seed,
    input int         idx,
    input sram_addr_t addr
  );
    return (addr[7:0] + 8'(idx) * 8'h35) ^ seed;
  endfunction

endpackage

`default_nettype wire

/* src/mem_test_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_test_regs #(
  parameter int SRAM_ADDR_W = mem_test_pkg::SRAM_ADDR_W
) (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [7:0]             paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   start,
  output logic [7:0]             seed,
  output logic [SRAM_ADDR_W:0]   len,
  input  logic                   done,
  input  logic                   pass,
  input  logic [15:0]            err_count,
  input  logic [SRAM_ADDR_W-1:0] err_addr
);
  import mem_test_pkg::*;

  logic busy;
  logic wr_en;
  logic addr_hit;

  assign wr_en = psel && penable && pwrite;

  // Zero wait states
  assign pready = 1'b1;
  assign pslverr = psel && penable && !addr_hit;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      start <= 1'b0;
      busy <= 1'b0;
      seed <= '0;
      len <= '0;
    end else begin
      // Start ignored while a run is in flight
      start <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT] && !busy && !start;
      if (start) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (wr_en && (paddr == REG_SEED)) begin
        seed <= pwdata[7:0];
      end
      if (wr_en && (paddr == REG_LEN)) begin
        len <= pwdata[SRAM_ADDR_W:0];
      end
    end
  end

  always_comb begin
    prdata = '0;
    addr_hit = 1'b1;
    case (paddr)
      REG_CTRL: prdata = '0;
      REG_SEED: prdata[7:0] = seed;
      REG_LEN: prdata[SRAM_ADDR_W:0] = len;
      REG_STATUS: begin
        prdata[STATUS_BUSY_BIT] = busy;
        prdata[STATUS_DONE_BIT] = done;
        prdata[STATUS_PASS_BIT] = pass;
      end
      REG_ERR_COUNT: prdata[15:0] = err_count;
      REG_ERR_ADDR: prdata[SRAM_ADDR_W-1:0] = err_addr;
      default: addr_hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* src/stripe_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stripe_sequencer #(
  parameter int NUM_S       = 4,
  parameter int SRAM_ADDR_W = mem_test_pkg::SRAM_ADDR_W
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [7:0]                seed,
  input  logic [SRAM_ADDR_W:0]      len,
  output mem_test_pkg::stripe_req_t req,
  output logic                      req_valid,
  input  logic                      req_ready
);
  import mem_test_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ
  } state_t;

  state_t               state;
  logic [SRAM_ADDR_W:0] cnt;
  logic [SRAM_ADDR_W:0] cnt_nxt;
  logic                 xfer;
  logic                 last;
  sram_addr_t           word_addr;

  assign req_valid = (state != ST_IDLE);
  assign xfer = req_valid && req_ready;
  assign cnt_nxt = cnt + 1'b1;
  assign last = (cnt_nxt == len);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Zero length run has nothing to issue
          if (start && (len != '0)) begin
            state <= ST_WRITE;
            cnt <= '0;
          end
        end
        ST_WRITE, ST_READ: begin
          if (xfer) begin
            if (last) begin
              state <= (state == ST_WRITE) ? ST_READ : ST_IDLE;
              cnt <= '0;
            end else begin
              cnt <= cnt_nxt;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    word_addr = '0;
    word_addr[SRAM_ADDR_W-1:0] = cnt[SRAM_ADDR_W-1:0];
  end

  // Unused stripe lanes stay zero
  always_comb begin
    req = '0;
    req.write = (state == ST_WRITE);
    req.addr = word_addr;
    for (int i = 0; i < NUM_S; i++) begin
      req.data[i] = pattern_byte(seed, i, word_addr);
    end
  end

endmodule

`default_nettype wire

/* src/sram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_port #(
  parameter int SRAM_ADDR_W = mem_test_pkg::SRAM_ADDR_W
) (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  mem_test_pkg::stripe_req_t req,
  input  logic [7:0]                stripe_data,
  input  logic                      req_valid,
  output logic                      req_ready,
  output mem_test_pkg::stripe_rsp_t rsp,
  output logic                      rsp_valid,
  output logic [SRAM_ADDR_W-1:0]    sram_addr,
  inout  wire  [7:0]                sram_data,
  output logic                      sram_we_n,
  output logic                      sram_oe_n
);

  // SETUP drives address, STROBE pulses we_n or oe_n
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_STROBE
  } state_t;

  state_t     state;
  logic       is_write;
  logic [7:0] wdata;
  logic       xfer;

  // Next request may land during the strobe cycle
  assign req_ready = (state != ST_SETUP);
  assign xfer = req_valid && req_ready;

  assign sram_data = ((state != ST_IDLE) && is_write) ? wdata : 'z;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      is_write <= 1'b0;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      rsp_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE, ST_STROBE: state <= xfer ? ST_SETUP : ST_IDLE;
        ST_SETUP: state <= ST_STROBE;
        default: state <= ST_IDLE;
      endcase
      if (xfer) begin
        is_write <= req.write;
      end
      // Strobes registered for clean edges on the chip
      sram_we_n <= !((state == ST_SETUP) && is_write);
      sram_oe_n <= !((state == ST_SETUP) && !is_write);
      rsp_valid <= (state == ST_STROBE) && !is_write;
    end
  end

  always_ff @(posedge CLK) begin
    if (xfer) begin
      sram_addr <= req.addr[SRAM_ADDR_W-1:0];
      wdata <= stripe_data;
    end
    // Sample at end of the oe_n cycle
    if ((state == ST_STROBE) && !is_write) begin
      rsp.data <= sram_data;
    end
  end

endmodule

`default_nettype wire

/* src/stripe_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module stripe_checker #(
  parameter int NUM_S       = 4,
  parameter int SRAM_ADDR_W = mem_test_pkg::SRAM_ADDR_W
) (
  input  logic                                  CLK,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic [7:0]                            seed,
  input  logic [SRAM_ADDR_W:0]                  len,
  input  mem_test_pkg::stripe_rsp_t [NUM_S-1:0] rsp,
  input  logic [NUM_S-1:0]                      rsp_valid,
  output logic                                  done,
  output logic                                  pass,
  output logic [15:0]                           err_count,
  output logic [SRAM_ADDR_W-1:0]                err_addr
);
  import mem_test_pkg::*;

  logic                 active;
  logic                 beat;
  logic [SRAM_ADDR_W:0] rd_cnt;
  logic [SRAM_ADDR_W:0] rd_cnt_nxt;
  sram_addr_t           rd_addr;
  logic [3:0]           n_bad;
  logic [16:0]          err_sum;

  // Ports run in lockstep, so all valids arrive together
  assign beat = active && (&rsp_valid);
  assign rd_cnt_nxt = rd_cnt + 1'b1;
  assign err_sum = {1'b0, err_count} + 17'(n_bad);
  assign pass = (err_count == '0);

  always_comb begin
    rd_addr = '0;
    rd_addr[SRAM_ADDR_W-1:0] = rd_cnt[SRAM_ADDR_W-1:0];
    n_bad = '0;
    for (int i = 0; i < NUM_S; i++) begin
      if (rsp[i].data != pattern_byte(seed, i, rd_addr)) begin
        n_bad = n_bad + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      active <= 1'b0;
      done <= 1'b0;
      rd_cnt <= '0;
      err_count <= '0;
      err_addr <= '0;
    end else if (start) begin
      active <= (len != '0);
      done <= (len == '0);
      rd_cnt <= '0;
      err_count <= '0;
      err_addr <= '0;
    end else if (beat) begin
      rd_cnt <= rd_cnt_nxt;
      // Saturate at 16 bits
      err_count <= err_sum[16] ? '1 : err_sum[15:0];
      if ((n_bad != '0) && (err_count == '0)) begin
        err_addr <= rd_cnt[SRAM_ADDR_W-1:0];
      end
      if (rd_cnt_nxt == len) begin
        active <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/mem_test_striped_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_test_striped_sram #(
  parameter int NUM_S       = 4,
  parameter int SRAM_ADDR_W = mem_test_pkg::SRAM_ADDR_W
) (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [7:0]                         paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic [NUM_S-1:0][SRAM_ADDR_W-1:0]  sram_addr,
  inout  wire  [NUM_S-1:0][7:0]              sram_data,
  output logic [NUM_S-1:0]                   sram_we_n,
  output logic [NUM_S-1:0]                   sram_oe_n
);
  import mem_test_pkg::*;

  logic                         start;
  logic [7:0]                   seed;
  logic [SRAM_ADDR_W:0]         len;
  stripe_req_t                  req;
  logic                         req_valid;
  logic                         req_ready;
  logic [NUM_S-1:0]             port_ready;
  stripe_rsp_t [NUM_S-1:0]      rsp;
  logic [NUM_S-1:0]             rsp_valid;
  logic                         done;
  logic                         pass;
  logic [15:0]                  err_count;
  logic [SRAM_ADDR_W-1:0]       err_addr;

  // Request moves only when every chip can take it
  assign req_ready = &port_ready;

  mem_test_regs #(
    .SRAM_ADDR_W(SRAM_ADDR_W)
  ) u_regs (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .start    (start),
    .seed     (seed),
    .len      (len),
    .done     (done),
    .pass     (pass),
    .err_count(err_count),
    .err_addr (err_addr)
  );

  stripe_sequencer #(
    .NUM_S      (NUM_S),
    .SRAM_ADDR_W(SRAM_ADDR_W)
  ) u_sequencer (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .start    (start),
    .seed     (seed),
    .len      (len),
    .req      (req),
    .req_valid(req_valid),
    .req_ready(req_ready)
  );

  for (genvar i = 0; i < NUM_S; i++) begin : g_port
    sram_port #(
      .SRAM_ADDR_W(SRAM_ADDR_W)
    ) u_port (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .req        (req),
      .stripe_data(req.data[i]),
      .req_valid  (req_valid),
      .req_ready  (port_ready[i]),
      .rsp        (rsp[i]),
      .rsp_valid  (rsp_valid[i]),
      .sram_addr  (sram_addr[i]),
      .sram_data  (sram_data[i]),
      .sram_we_n  (sram_we_n[i]),
      .sram_oe_n  (sram_oe_n[i])
    );
  end

  stripe_checker #(
    .NUM_S      (NUM_S),
    .SRAM_ADDR_W(SRAM_ADDR_W)
  ) u_checker (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .start    (start),
    .seed     (seed),
    .len      (len),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .done     (done),
    .pass     (pass),
    .err_count(err_count),
    .err_addr (err_addr)
  );

endmodule

`default_nettype wire

/* sim/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter int         ADDR_W = 10,
  parameter logic [7:0] FILL   = 8'h00
) (
  input  wire [ADDR_W-1:0] addr,
  inout  wire [7:0]        data,
  input  wire              we_n,
  input  wire              oe_n,
  input  wire [7:0]        stuck_mask
);

  logic [7:0] mem [2**ADDR_W];

  // Every address bit folded into the fill byte
  function automatic logic [7:0] fill_byte(input int unsigned a);
    logic [7:0] f;
    f = FILL;
    for (int s = 0; s < ADDR_W; s += 8) begin
      f = f ^ 8'(a >> s);
    end
    return f;
  endfunction

  initial begin
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a] = fill_byte(a);
    end
  end

  // Address and data settle a cycle before we_n falls
  always @(negedge we_n) begin
    mem[addr] = data;
  end

  // Stuck bits only show on the read path
  assign data = (!oe_n && we_n) ? (mem[addr] | stuck_mask) : 8'hzz;

endmodule

`default_nettype wire

/* sim/tb_mem_test_striped_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_test_striped_sram;
  import mem_test_pkg::*;

  localparam int NUM_S = 4;
  localparam int ADDR_W = 10;
  localparam int DEPTH = 2**ADDR_W;
  localparam int DRV = 2;

  // Kinds of APB read result
  localparam int K_SKIP = 0;
  localparam int K_WORD = 1;
  localparam int K_STATUS = 2;
  localparam int K_SLVERR = 3;

  logic                        CLK;
  logic                        rst_n;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [7:0]                  paddr;
  logic [31:0]                 pwdata;
  wire  [31:0]                 prdata;
  wire                         pready;
  wire                         pslverr;
  wire  [NUM_S-1:0][ADDR_W-1:0] sram_addr;
  wire  [NUM_S-1:0][7:0]       sram_data;
  wire  [NUM_S-1:0]            sram_we_n;
  wire  [NUM_S-1:0]            sram_oe_n;
  logic [7:0]                  stuck_mask;
  logic [31:0]                 rd_data;

  int errors;
  int checks;
  int tests;
  int failed_tests;
  int budget;

  string       name_q[$];
  int          kind_q[$];
  logic [31:0] exp_q[$];

  mem_test_striped_sram #(
    .NUM_S      (NUM_S),
    .SRAM_ADDR_W(ADDR_W)
  ) dut (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n)
  );

  for (genvar i = 0; i < NUM_S; i++) begin : g_chip
    sram_model #(
      .ADDR_W(ADDR_W),
      .FILL  (8'(8'hC0 + i))
    ) u_sram (
      .addr      (sram_addr[i]),
      .data      (sram_data[i]),
      .we_n      (sram_we_n[i]),
      .oe_n      (sram_oe_n[i]),
      .stuck_mask((i == 2) ? stuck_mask : 8'h00)
    );
  end

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Low address byte plus 53 per chip, xor seed
  function automatic logic [7:0] ref_byte(input logic [7:0] seed, input int chip, input int addr);
    int sum;
    sum = (addr % 256) + chip * 53;
    return 8'(sum % 256) ^ seed;
  endfunction

  function automatic logic [7:0] fill_ref(input int chip, input int addr);
    return 8'(addr) ^ 8'(addr >> 8) ^ 8'(8'hC0 + chip);
  endfunction

  function automatic logic [7:0] peek_model(input int chip, input int addr);
    case (chip)
      0: return g_chip[0].u_sram.mem[addr];
      1: return g_chip[1].u_sram.mem[addr];
      2: return g_chip[2].u_sram.mem[addr];
      default: return g_chip[3].u_sram.mem[addr];
    endcase
  endfunction

  function automatic logic [31:0] status_word(input logic busy, input logic done, input logic pass);
    logic [31:0] w;
    w = '0;
    w[STATUS_BUSY_BIT] = busy;
    w[STATUS_DONE_BIT] = done;
    w[STATUS_PASS_BIT] = pass;
    return w;
  endfunction

  task automatic word_check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic status_check(input logic [31:0] got, input logic busy, input logic done,
                              input logic pass);
    logic [2:0] g;
    logic [2:0] e;
    g = {got[STATUS_PASS_BIT], got[STATUS_DONE_BIT], got[STATUS_BUSY_BIT]};
    e = {pass, done, busy};
    checks++;
    if (g !== e) begin
      errors++;
      $display("Mismatch STATUS {pass,done,busy}: got 0x%01h, expected 0x%01h", g, e);
    end
  endtask

  task automatic byte_check(input string name, input stripe_rsp_t got, input stripe_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got.data, exp.data);
    end
  endtask

  // Both APB tasks start and end 2 ns after a rising edge
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge CLK);
    #DRV;
    penable = 1'b1;
    @(posedge CLK);
    #DRV;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input int kind, input string name,
                          input logic [31:0] exp, output logic [31:0] data);
    name_q.push_back(name);
    kind_q.push_back(kind);
    exp_q.push_back(exp);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge CLK);
    #DRV;
    penable = 1'b1;
    @(negedge CLK);
    data = prdata;
    @(posedge CLK);
    #DRV;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // Checks each APB read against the value queued with it
  initial begin : compare_reads
    string       name;
    int          kind;
    logic [31:0] exp;
    forever begin
      @(negedge CLK);
      if (psel && penable && !pwrite) begin
        if (kind_q.size() == 0) begin
          errors++;
          $display("APB read at offset 0x%02h had no expected value queued", paddr);
        end else begin
          name = name_q.pop_front();
          kind = kind_q.pop_front();
          exp = exp_q.pop_front();
          word_check({name, ".pready"}, 32'(pready), 32'h1);
          if (kind == K_SLVERR) begin
            word_check({name, ".pslverr"}, 32'(pslverr), 32'h1);
          end else if (pslverr) begin
            errors++;
            $display("Unexpected slave error on read of %s", name);
          end else if (kind == K_WORD) begin
            word_check(name, prdata, exp);
          end else if (kind == K_STATUS) begin
            status_check(prdata, exp[STATUS_BUSY_BIT], exp[STATUS_DONE_BIT],
                         exp[STATUS_PASS_BIT]);
          end
        end
      end
    end
  end

  task automatic start_run(input logic [7:0] seed, input int len);
    write_reg(REG_SEED, 32'(seed));
    write_reg(REG_LEN, 32'(len));
    write_reg(REG_CTRL, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[STATUS_DONE_BIT]) begin
      read_reg(REG_STATUS, K_SKIP, "STATUS poll", '0, st);
    end
  endtask

  task automatic results_check(input logic pass, input int cnt, input int addr);
    read_reg(REG_STATUS, K_STATUS, "STATUS", status_word(1'b0, 1'b1, pass), rd_data);
    read_reg(REG_ERR_COUNT, K_WORD, "ERR_COUNT", 32'(cnt), rd_data);
    read_reg(REG_ERR_ADDR, K_WORD, "ERR_ADDR", 32'(addr), rd_data);
  endtask

  task automatic contents_check(input logic [7:0] seed, input int len, input bit above);
    stripe_rsp_t got;
    stripe_rsp_t exp;
    for (int c = 0; c < NUM_S; c++) begin
      for (int a = 0; a < DEPTH; a++) begin
        got = peek_model(c, a);
        if (a < len) begin
          exp = ref_byte(seed, c, a);
        end else begin
          exp = fill_ref(c, a);
        end
        if ((a < len) || above) begin
          byte_check($sformatf("chip%0d mem[0x%03h]", c, a), got, exp);
        end
      end
    end
  endtask

  task automatic test_done(input string desc, input int errs_at);
    tests++;
    if (errors == errs_at) begin
      $display("Test %s: ok", desc);
    end else begin
      failed_tests++;
      $display("Test %s: %0d errors", desc, errors - errs_at);
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (budget > 0);
    while (cycles < budget) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [7:0] seed2;
    logic [7:0] seed3;
    logic [7:0] seed4;
    logic [7:0] seed5;
    logic [7:0] b;
    int         len4;
    int         len5;
    int         exp_cnt;
    int         first_bad;
    int         errs_at;
    void'($urandom(32'h9942_82ea));
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    seed2 = 8'($urandom);
    seed3 = seed2 ^ 8'(1 + $urandom % 255);
    seed4 = 8'($urandom);
    seed5 = 8'($urandom);
    len4 = 16 + int'($urandom % 240);
    len5 = 16 + int'($urandom % 112);
    // 4 cycles per word plus APB overhead for each of five tests
    budget = 5 * 20 + 4 * (64 + DEPTH + len4 + len5) + 200;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    stuck_mask = 8'h00;
    repeat (8) @(posedge CLK);
    #DRV;
    rst_n = 1'b1;

    errs_at = errors;
    read_reg(REG_STATUS, K_STATUS, "STATUS", status_word(1'b0, 1'b0, 1'b1), rd_data);
    read_reg(REG_ERR_COUNT, K_WORD, "ERR_COUNT", 32'h0, rd_data);
    read_reg(REG_ERR_ADDR, K_WORD, "ERR_ADDR", 32'h0, rd_data);
    test_done("1 reset values", errs_at);

    errs_at = errors;
    start_run(seed2, 64);
    wait_done();
    results_check(1'b1, 0, 0);
    contents_check(seed2, 64, 1'b1);
    test_done($sformatf("2 seed 0x%02h len 64", seed2), errs_at);

    errs_at = errors;
    start_run(seed3, DEPTH);
    wait_done();
    results_check(1'b1, 0, 0);
    contents_check(seed3, DEPTH, 1'b0);
    test_done($sformatf("3 seed 0x%02h full range", seed3), errs_at);

    // Chip 2 bit 3 stuck at one
    errs_at = errors;
    exp_cnt = 0;
    first_bad = 0;
    for (int a = len4 - 1; a >= 0; a--) begin
      b = ref_byte(seed4, 2, a);
      if (!b[3]) begin
        exp_cnt++;
        first_bad = a;
      end
    end
    stuck_mask = 8'h08;
    start_run(seed4, len4);
    wait_done();
    results_check(exp_cnt == 0, exp_cnt, first_bad);
    contents_check(seed4, len4, 1'b0);
    stuck_mask = 8'h00;
    test_done($sformatf("4 stuck bit, len %0d", len4), errs_at);

    errs_at = errors;
    read_reg(8'h20, K_SLVERR, "offset 0x20", '0, rd_data);
    start_run(seed5, len5);
    read_reg(REG_STATUS, K_STATUS, "STATUS", status_word(1'b1, 1'b0, 1'b1), rd_data);
    // Restart attempt once the read phase is under way
    wait (sram_oe_n[0] === 1'b0);
    #DRV;
    write_reg(REG_CTRL, 32'h1);
    wait_done();
    results_check(1'b1, 0, 0);
    contents_check(seed5, len5, 1'b0);
    test_done($sformatf("5 slave error and restart, len %0d", len5), errs_at);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/mem_test_pkg.sv
src/mem_test_regs.sv
src/stripe_sequencer.sv
src/sram_port.sv
src/stripe_checker.sv
src/mem_test_striped_sram.sv
sim/sram_model.sv
sim/tb_mem_test_striped_sram.sv

/* Bender.yml */
package:
  name: mem_test_striped_sram

sources:
  - files:
      - src/mem_test_pkg.sv
      - src/mem_test_regs.sv
      - src/stripe_sequencer.sv
      - src/sram_port.sv
      - src/stripe_checker.sv
      - src/mem_test_striped_sram.sv
  - target: test
    files:
      - sim/sram_model.sv
      - sim/tb_mem_test_striped_sram.sv
